//--- files.f
src/opl_pkg.sv
src/opl_decode.sv
src/opl_ch_ring.sv
src/opl_op_ring.sv
src/opl_regs.sv
src/opl_top.sv
testbench/tb_clock.sv
testbench/tb_opl_assert.sv
testbench/tb_opl.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_opl -o Vtb_opl \
    && ./obj_dir/Vtb_opl | tee /dev/stderr | grep -q "Simulation finished: PASS" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

//--- src/opl_ch_ring.sv
// resettable channel configuration shift ring, one per operator group
`timescale 1ns/1ps
`default_nettype none

module opl_ch_ring (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cen,
    input  opl_pkg::ch_cfg_t din,
    output opl_pkg::ch_cfg_t drop
);
    import opl_pkg::*;

    // one word per channel of the group
    logic [CHCFG_W-1:0] stage [CH_STAGES];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < CH_STAGES; i++) begin
                stage[i] <= '0;
            end
        end else if (cen) begin
            stage[0] <= din;
            for (int i = 1; i < CH_STAGES; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // oldest word is the current channel
    assign drop = ch_cfg_t'(stage[CH_STAGES-1]);

endmodule

`default_nettype wire

//--- src/opl_decode.sv
// host byte port: address latch, register kind decode, target slot and fnum low latch
`timescale 1ns/1ps
`default_nettype none

module opl_decode (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          wr,
    input  logic          a0,
    input  logic [7:0]    din,
    output opl_pkg::upd_t upd,
    output logic          write
);
    import opl_pkg::*;

    logic [7:0] addr;
    reg_kind_e  op_kind;
    reg_kind_e  dec_kind;
    logic       op_ok;
    logic       ch_ok;
    logic [1:0] ch_group;
    logic [2:0] ch_sub;
    logic [1:0] dec_group;
    logic [2:0] dec_sub;
    logic       fnum_wr;

    // operator block from the upper address bits
    always_comb begin
        case (addr[7:5])
            3'd1:    op_kind = REG_MULT;
            3'd2:    op_kind = REG_KSL_TL;
            3'd3:    op_kind = REG_AR_DR;
            3'd4:    op_kind = REG_SL_RR;
            default: op_kind = REG_NONE;
        endcase
    end

    // offset group 3 and subslots 6-7 are holes
    assign op_ok = (addr[4:3] != 2'(NUM_GROUPS)) && (addr[2:0] < 3'(SUBS_PER_GROUP));
    assign ch_ok = addr[3:0] < 4'(NUM_CH);

    // channel to group and modulator subslot
    always_comb begin
        if (addr[3:0] >= 4'd6) begin
            ch_group = 2'd2;
            ch_sub   = 3'(addr[3:0] - 4'd6);
        end else if (addr[3:0] >= 4'd3) begin
            ch_group = 2'd1;
            ch_sub   = 3'(addr[3:0] - 4'd3);
        end else begin
            ch_group = 2'd0;
            ch_sub   = addr[2:0];
        end
    end

    always_comb begin
        dec_kind  = REG_NONE;
        dec_group = '0;
        dec_sub   = '0;
        fnum_wr   = 1'b0;
        if (op_kind != REG_NONE) begin
            if (op_ok) begin
                dec_kind  = op_kind;
                dec_group = addr[4:3];
                dec_sub   = addr[2:0];
            end
        end else if (ch_ok) begin
            case (addr[7:4])
                // low byte only waits for the high byte
                4'hA: fnum_wr = 1'b1;
                4'hB: dec_kind = REG_FNUM_HI;
                4'hC: dec_kind = REG_FBCON;
                default: dec_kind = REG_NONE;
            endcase
            dec_group = ch_group;
            dec_sub   = ch_sub;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr          <= '0;
            write         <= 1'b0;
            upd.kind      <= REG_NONE;
            upd.sel_group <= '0;
            upd.sel_sub   <= '0;
            upd.data      <= '0;
            upd.fnum_lo   <= '0;
        end else begin
            // one pulse per data write
            write <= wr && a0;
            if (wr && !a0) begin
                addr <= din;
            end
            if (wr && a0) begin
                upd.kind      <= dec_kind;
                upd.sel_group <= dec_group;
                upd.sel_sub   <= dec_sub;
                upd.data      <= din;
                if (fnum_wr) begin
                    upd.fnum_lo <= din;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/opl_op_ring.sv
// circulating operator configuration ring with per-field updates at their read stage
`timescale 1ns/1ps
`default_nettype none

module opl_op_ring (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    input  logic [7:0]         din,
    input  opl_pkg::reg_kind_e kind,
    input  logic               update_op_I,
    input  logic               update_op_II,
    input  logic               update_op_IV,
    output opl_pkg::op_cfg_t   shift_out
);
    import opl_pkg::*;

    logic [OPCFG_W-1:0] ring [NUM_OPS];
    op_cfg_t            drop;
    logic               up_mult_I;
    logic               up_mult_II;
    logic               up_ksl_I;
    logic               up_tl_IV;
    logic               up_ar_dr_I;
    logic               up_sl_rr_I;

    assign drop = op_cfg_t'(ring[NUM_OPS-1]);

    // field group write enables
    assign up_mult_I  = (kind == REG_MULT) && update_op_I;
    assign up_mult_II = (kind == REG_MULT) && update_op_II;
    assign up_ksl_I   = (kind == REG_KSL_TL) && update_op_I;
    assign up_tl_IV   = (kind == REG_KSL_TL) && update_op_IV;
    assign up_ar_dr_I = (kind == REG_AR_DR) && update_op_I;
    assign up_sl_rr_I = (kind == REG_SL_RR) && update_op_I;

    // patched word, shown now and fed back into the ring
    always_comb begin
        shift_out = drop;
        if (up_mult_I) begin
            shift_out.am     = din[7];
            shift_out.vib    = din[6];
            shift_out.en_sus = din[5];
        end
        // ks and mul lag one slot
        if (up_mult_II) begin
            shift_out.ks  = din[4];
            shift_out.mul = din[3:0];
        end
        if (up_ksl_I) begin
            shift_out.ksl = din[7:6];
        end
        // tl lags three slots
        if (up_tl_IV) begin
            shift_out.tl = din[5:0];
        end
        if (up_ar_dr_I) begin
            shift_out.ar = din[7:4];
            shift_out.dr = din[3:0];
        end
        if (up_sl_rr_I) begin
            shift_out.sl = din[7:4];
            shift_out.rr = din[3:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_OPS; i++) begin
                ring[i] <= '0;
            end
        end else if (cen) begin
            ring[0] <= shift_out;
            for (int i = 1; i < NUM_OPS; i++) begin
                ring[i] <= ring[i-1];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/opl_pkg.sv
// package: slot geometry constants, update kinds, slot, update and configuration structs
`default_nettype none

package opl_pkg;

    // slot geometry
    localparam int NUM_GROUPS     = 3;
    // subslots 0-2 modulators, 3-5 carriers
    localparam int SUBS_PER_GROUP = 6;
    localparam int NUM_OPS        = 18;
    localparam int NUM_CH         = 9;
    // one ring stage per channel of a group
    localparam int CH_STAGES      = 3;

    // configuration word widths
    localparam int OPCFG_W = 32;
    localparam int CHCFG_W = 18;

    // register kind of the last data write
    typedef enum logic [2:0] {
        REG_NONE,
        REG_MULT,
        REG_KSL_TL,
        REG_AR_DR,
        REG_SL_RR,
        REG_FNUM_LO,
        REG_FNUM_HI,
        REG_FBCON
    } reg_kind_e;

    // counter position, zero marks group 0 subslot 0
    typedef struct packed {
        logic       zero;
        logic [1:0] group;
        logic [2:0] sub;
        logic       op;
    } slot_pos_t;

    // held decode result
    typedef struct packed {
        reg_kind_e  kind;
        logic [1:0] sel_group;
        logic [2:0] sel_sub;
        logic [7:0] data;
        logic [7:0] fnum_lo;
    } upd_t;

    // operator word, fields read at stages I, II and IV
    typedef struct packed {
        logic       am;
        logic       vib;
        logic       en_sus;
        logic       ks;
        logic [3:0] mul;
        logic [1:0] ksl;
        logic [5:0] tl;
        logic [3:0] ar;
        logic [3:0] dr;
        logic [3:0] sl;
        logic [3:0] rr;
    } op_cfg_t;

    // channel word
    typedef struct packed {
        logic       keyon;
        logic [2:0] block;
        logic [9:0] fnum;
        logic [2:0] fb;
        logic       con;
    } ch_cfg_t;

endpackage

`default_nettype wire

//--- src/opl_regs.sv
// register block: slot counter, update stage pipeline, channel muxing and ring instances
`timescale 1ns/1ps
`default_nettype none

module opl_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    input  logic                write,
    input  opl_pkg::upd_t       upd,
    output opl_pkg::slot_pos_t  slot,
    output opl_pkg::op_cfg_t    op_cfg,
    output opl_pkg::ch_cfg_t    ch_cfg
);
    import opl_pkg::*;

    logic [1:0] next_group;
    logic [2:0] next_sub;
    logic       match;
    logic       update_op_I;
    logic       update_op_II;
    logic       update_op_III;
    logic       update_op_IV;
    reg_kind_e  kind_live;
    logic       up_fnum_ch;
    logic       up_fbcon_ch;
    ch_cfg_t    ch_drop;
    ch_cfg_t    ch_out [NUM_GROUPS];
    ch_cfg_t    ch_in  [NUM_GROUPS];

    // six subslots per group, three groups per turn
    always_comb begin
        if (slot.sub == 3'(SUBS_PER_GROUP - 1)) begin
            next_sub   = '0;
            next_group = (slot.group == 2'(NUM_GROUPS - 1)) ? 2'd0 : slot.group + 2'd1;
        end else begin
            next_sub   = slot.sub + 3'd1;
            next_group = slot.group;
        end
    end

    // zero, op and match belong to the slot being entered
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot.zero  <= 1'b1;
            slot.group <= '0;
            slot.sub   <= '0;
            slot.op    <= 1'b0;
            match      <= (upd.sel_group == 2'd0) && (upd.sel_sub == 3'd0);
        end else if (cen) begin
            slot.group <= next_group;
            slot.sub   <= next_sub;
            slot.zero  <= (next_group == 2'd0) && (next_sub == 3'd0);
            slot.op    <= next_sub >= 3'(SUBS_PER_GROUP / 2);
            match      <= (next_group == upd.sel_group) && (next_sub == upd.sel_sub);
        end else if (write) begin
            // new target while the slot holds still
            match <= (slot.group == upd.sel_group) && (slot.sub == upd.sel_sub);
        end
    end

    // stage I hit on the target slot
    assign update_op_I = !write && (upd.sel_group == slot.group) && (upd.sel_sub == slot.sub);

    // later stages follow the slot, a new write flushes them
    always_ff @(posedge clk) begin
        if (!rst_n || write) begin
            update_op_II  <= 1'b0;
            update_op_III <= 1'b0;
            update_op_IV  <= 1'b0;
        end else if (cen) begin
            update_op_II  <= update_op_I;
            update_op_III <= update_op_II;
            update_op_IV  <= update_op_III;
        end
    end

    // match and stages still point at the old target on the write cycle
    assign kind_live   = write ? REG_NONE : upd.kind;
    assign up_fnum_ch  = (kind_live == REG_FNUM_HI) && match;
    assign up_fbcon_ch = (kind_live == REG_FBCON) && match;

    opl_op_ring u_op_ring (
        .clk          (clk),
        .rst_n        (rst_n),
        .cen          (cen),
        .din          (upd.data),
        .kind         (kind_live),
        .update_op_I  (update_op_I),
        .update_op_II (update_op_II),
        .update_op_IV (update_op_IV),
        .shift_out    (op_cfg)
    );

    // ring of the active group
    always_comb begin
        case (slot.group)
            2'd1:    ch_drop = ch_out[1];
            2'd2:    ch_drop = ch_out[2];
            default: ch_drop = ch_out[0];
        endcase
    end

    // new channel fields merged into the current word
    always_comb begin
        ch_cfg = ch_drop;
        if (up_fnum_ch) begin
            {ch_cfg.keyon, ch_cfg.block, ch_cfg.fnum} = {upd.data[5:0], upd.fnum_lo};
        end
        if (up_fbcon_ch) begin
            ch_cfg.fb  = upd.data[3:1];
            ch_cfg.con = upd.data[0];
        end
    end

    // idle groups just recirculate
    for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_group
        assign ch_in[g] = (slot.group == 2'(g)) ? ch_cfg : ch_out[g];

        opl_ch_ring u_ch_ring (
            .clk   (clk),
            .rst_n (rst_n),
            .cen   (cen),
            .din   (ch_in[g]),
            .drop  (ch_out[g])
        );
    end

endmodule

`default_nettype wire

//--- src/opl_top.sv
// top level: host decoder feeding the register block
`timescale 1ns/1ps
`default_nettype none

module opl_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    input  logic               wr,
    input  logic               a0,
    input  logic [7:0]         din,
    output opl_pkg::slot_pos_t slot,
    output opl_pkg::op_cfg_t   op_cfg,
    output opl_pkg::ch_cfg_t   ch_cfg
);
    import opl_pkg::*;

    // held update and its write pulse
    upd_t upd;
    logic write;

    opl_decode u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .a0    (a0),
        .din   (din),
        .upd   (upd),
        .write (write)
    );

    // slot walk and configuration storage
    opl_regs u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen),
        .write  (write),
        .upd    (upd),
        .slot   (slot),
        .op_cfg (op_cfg),
        .ch_cfg (ch_cfg)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
// testbench clock source, 100 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);
    // half of the 100 ns period
    localparam time HALF = 50ns;

    initial clk = 1'b0;
    always #(HALF) clk = ~clk;

endmodule

`default_nettype wire

//--- testbench/tb_opl.sv
// testbench top: host writes, shadow model, reference function, compare process, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_opl;
    import opl_pkg::*;

    // cens after a data write before its fields are compared
    localparam int SETTLE_CENS = 21;
    // settle plus one full turn of checking
    localparam int WAIT_CENS   = SETTLE_CENS + NUM_OPS;
    localparam int NUM_WRITES  = 12 + 6 + 4 + 5;
    localparam int WALK_CENS   = 40;
    // about 2 clocks per cen plus write overhead
    localparam int LIMIT_CYCLES = NUM_WRITES * (2 * WAIT_CENS + 12) + 2 * WALK_CENS + 200;

    logic       clk;
    logic       rst_n;
    logic       cen;
    logic       wr;
    logic       a0;
    logic [7:0] din;
    slot_pos_t  slot;
    op_cfg_t    op_cfg;
    ch_cfg_t    ch_cfg;

    // shadow of the register contents
    op_cfg_t    shadow_op [NUM_OPS];
    ch_cfg_t    shadow_ch [NUM_CH];
    logic [7:0] shadow_lo;
    int         pos;
    int         since_write;
    string      cur_test;

    tb_clock u_clock (.clk(clk));

    opl_top opl_top_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen),
        .wr     (wr),
        .a0     (a0),
        .din    (din),
        .slot   (slot),
        .op_cfg (op_cfg),
        .ch_cfg (ch_cfg)
    );

    bind opl_regs tb_opl_assert u_regs_assert (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .slot  (slot),
        .upd   (upd)
    );

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s expected %h actual %h", cur_test, what, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    // OPL register map applied to the shadow
    task automatic model_write(input logic [7:0] addr, input logic [7:0] data);
        int idx;
        int ch;
        idx = int'(addr[4:3]) * SUBS_PER_GROUP + int'(addr[2:0]);
        ch  = int'(addr[3:0]);
        if (addr[7:5] >= 3'd1 && addr[7:5] <= 3'd4) begin
            if (addr[4:3] != 2'd3 && addr[2:0] < 3'd6) begin
                case (addr[7:5])
                    3'd1: begin
                        shadow_op[idx].am     = data[7];
                        shadow_op[idx].vib    = data[6];
                        shadow_op[idx].en_sus = data[5];
                        shadow_op[idx].ks     = data[4];
                        shadow_op[idx].mul    = data[3:0];
                    end
                    3'd2: begin
                        shadow_op[idx].ksl = data[7:6];
                        shadow_op[idx].tl  = data[5:0];
                    end
                    3'd3: begin
                        shadow_op[idx].ar = data[7:4];
                        shadow_op[idx].dr = data[3:0];
                    end
                    default: begin
                        shadow_op[idx].sl = data[7:4];
                        shadow_op[idx].rr = data[3:0];
                    end
                endcase
            end
        end else if (ch < NUM_CH) begin
            if (addr[7:4] == 4'hA) begin
                shadow_lo = data;
            end else if (addr[7:4] == 4'hB) begin
                shadow_ch[ch].keyon = data[5];
                shadow_ch[ch].block = data[4:2];
                shadow_ch[ch].fnum  = {data[1:0], shadow_lo};
            end else if (addr[7:4] == 4'hC) begin
                shadow_ch[ch].fb  = data[3:1];
                shadow_ch[ch].con = data[0];
            end
        end
    endtask

    // operator word seen at slot p: mul/ks one slot late, tl three slots late
    function automatic op_cfg_t expected_op(input int p);
        op_cfg_t r;
        r     = shadow_op[p];
        r.ks  = shadow_op[(p + NUM_OPS - 1) % NUM_OPS].ks;
        r.mul = shadow_op[(p + NUM_OPS - 1) % NUM_OPS].mul;
        r.tl  = shadow_op[(p + NUM_OPS - 3) % NUM_OPS].tl;
        return r;
    endfunction

    // carriers share the channel of their modulator
    function automatic ch_cfg_t expected_ch(input int p);
        return shadow_ch[(p / SUBS_PER_GROUP) * 3 + (p % SUBS_PER_GROUP) % 3];
    endfunction

    task automatic wait_cens(input int n);
        repeat (n) begin
            @(posedge clk);
            while (!cen) @(posedge clk);
        end
    endtask

    // address then data; data strobe phase against cen follows the data
    task automatic host_write(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        #5;
        wr  = 1'b1;
        a0  = 1'b0;
        din = addr;
        @(posedge clk);
        #5;
        wr = 1'b0;
        @(posedge clk);
        // odd data puts the write pulse on a cen cycle, even data between two
        if (data[0]) begin
            @(posedge clk);
        end
        #5;
        wr  = 1'b1;
        a0  = 1'b1;
        din = data;
        model_write(addr, data);
        since_write = 0;
        @(posedge clk);
        #5;
        wr = 1'b0;
        a0 = 1'b0;
        wait_cens(WAIT_CENS);
    endtask

    // cen toggles every clock
    always begin
        @(posedge clk);
        #5;
        cen = ~cen;
    end

    // compare on the falling edge, outputs are settled there
    always @(negedge clk) begin
        slot_pos_t exp_slot;
        op_cfg_t   eo;
        ch_cfg_t   ec;
        if (!rst_n) begin
            pos = 0;
        end else if (cen) begin
            exp_slot.zero  = (pos == 0);
            exp_slot.group = 2'(pos / SUBS_PER_GROUP);
            exp_slot.sub   = 3'(pos % SUBS_PER_GROUP);
            exp_slot.op    = (pos % SUBS_PER_GROUP) >= 3;
            check("slot", 32'(exp_slot), 32'(slot));
            if (since_write >= SETTLE_CENS) begin
                eo = expected_op(pos);
                ec = expected_ch(pos);
                check("stage I", 32'({eo.am, eo.vib, eo.en_sus, eo.ksl, eo.ar, eo.dr,
                      eo.sl, eo.rr}), 32'({op_cfg.am, op_cfg.vib, op_cfg.en_sus,
                      op_cfg.ksl, op_cfg.ar, op_cfg.dr, op_cfg.sl, op_cfg.rr}));
                check("stage II", 32'({eo.ks, eo.mul}), 32'({op_cfg.ks, op_cfg.mul}));
                check("stage IV", 32'(eo.tl), 32'(op_cfg.tl));
                check("channel", 32'(ec), 32'(ch_cfg));
            end else begin
                since_write++;
            end
            pos = (pos + 1) % NUM_OPS;
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        logic [7:0] base [4];
        logic [7:0] holes [5];
        int         ch;
        base  = '{8'h20, 8'h40, 8'h60, 8'h80};
        // sub 6, sub 7, group 3, channel 9, unmapped
        holes = '{8'h2E, 8'h47, 8'h78, 8'hB9, 8'hF0};
        void'($urandom(32'h8d02));
        rst_n       = 1'b0;
        cen         = 1'b0;
        wr          = 1'b0;
        a0          = 1'b0;
        din         = '0;
        shadow_lo   = '0;
        since_write = SETTLE_CENS;
        pos         = 0;
        cur_test    = "reset";
        for (int i = 0; i < NUM_OPS; i++) begin
            shadow_op[i] = '0;
        end
        for (int i = 0; i < NUM_CH; i++) begin
            shadow_ch[i] = '0;
        end
        repeat (8) @(posedge clk);
        #5;
        rst_n = 1'b1;

        cur_test = "slot_walk";
        wait_cens(WALK_CENS);

        cur_test = "op_regs";
        for (int i = 0; i < 12; i++) begin
            host_write(base[$urandom % 4] + 8'(($urandom % 3) * 8) + 8'($urandom % 6),
                       8'($urandom));
        end

        // low byte alone first, then the high byte commits it
        cur_test = "fnum";
        for (int i = 0; i < 3; i++) begin
            ch = int'($urandom % NUM_CH);
            host_write(8'hA0 + 8'(ch), 8'($urandom));
            host_write(8'hB0 + 8'(ch), 8'($urandom));
        end

        cur_test = "fbcon";
        for (int i = 0; i < 4; i++) begin
            host_write(8'hC0 + 8'($urandom % NUM_CH), 8'($urandom));
        end

        cur_test = "unused";
        for (int i = 0; i < 5; i++) begin
            host_write(holes[i], 8'($urandom));
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_opl_assert.sv
// concurrent assertions on the slot counter and the held decode result
`timescale 1ns/1ps
`default_nettype none

module tb_opl_assert (
    input logic               clk,
    input logic               rst_n,
    input logic               cen,
    input opl_pkg::slot_pos_t slot,
    input opl_pkg::upd_t      upd
);
    import opl_pkg::*;

    // cens since zero was last seen high at a cen edge, 0 until the first one
    int unsigned cens_since_zero;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cens_since_zero <= 0;
        end else if (cen) begin
            cens_since_zero <= slot.zero ? 1 : cens_since_zero + 1;
        end
    end

    // counter never leaves the 3 x 6 grid
    a_slot_range: assert property (@(posedge clk) disable iff (!rst_n)
        (slot.group < 2'(NUM_GROUPS)) && (slot.sub < 3'(SUBS_PER_GROUP)))
        else $error("slot counter outside the 3 x 6 grid");

    // one zero per turn of 18 cens
    a_zero_period: assert property (@(posedge clk) disable iff (!rst_n)
        (cen && cens_since_zero != 0) |-> (slot.zero == (cens_since_zero == NUM_OPS)))
        else $error("zero pulse not once per 18 cens");

    a_zero_reset: assert property (@(posedge clk) !rst_n |=> slot.zero)
        else $error("zero low during reset");

    a_kind_reset: assert property (@(posedge clk) !rst_n |=> (upd.kind == REG_NONE))
        else $error("update kind not cleared by reset");

endmodule

`default_nettype wire
